/* dcache_system.f */
src/dcache_pkg.sv
src/mem_bus_pkg.sv
src/ram_clear.sv
src/dcache.sv
src/bus_memory.sv
src/dcache_system.sv
test/dcache_system_properties.sv
test/dcache_system_tb.sv

/* src/bus_memory.sv */
`timescale 1ns/1ps

module bus_memory #(
	parameter int MEM_ADDR_BITS = 8,
	parameter int MEM_LATENCY = 3
) (
	input logic i_clock,
	input logic i_reset,
	input logic i_request,
	input mem_bus_pkg::bus_req_t i_req,
	output logic o_ready,
	output mem_bus_pkg::word_t o_rdata
);

	import mem_bus_pkg::*;

	localparam int COUNT_BITS = $clog2(MEM_LATENCY + 1);

	logic initialized;
	logic busy;
	logic [COUNT_BITS-1:0] count;
	logic [MEM_ADDR_BITS-1:0] word_address;
	logic ram_write;
	word_t ram_wdata;

	// Word index, upper address bits wrap.
	assign word_address = i_req.address[MEM_ADDR_BITS+1:2];
	assign ram_wdata = i_req.wdata;
	assign ram_write = o_ready && i_req.rw;

	ram_clear #(
		.DEPTH_BITS(MEM_ADDR_BITS),
		.T_WORD(word_t),
		.CLEAR_VALUE('0)
	) u_ram (
		.i_clock(i_clock),
		.i_reset(i_reset),
		.i_write(ram_write),
		.i_address(word_address),
		.i_wdata(ram_wdata),
		.o_rdata(o_rdata),
		.o_initialized(initialized)
	);

	// ==============================
	// Latency counter
	// ==============================

	// A transaction only starts once the array is cleared.
	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			busy <= 1'b0;
			count <= '0;
		end else if (!busy) begin
			if (i_request && initialized) begin
				busy <= 1'b1;
				count <= COUNT_BITS'(1);
			end
		end else if (o_ready) begin
			busy <= 1'b0;
		end else begin
			count <= count + 1'b1;
		end
	end

	// Count equals the cycle number inside the transaction.
	assign o_ready = busy && (count == COUNT_BITS'(MEM_LATENCY));

endmodule

/* src/dcache.sv */
`timescale 1ns/1ps

module dcache #(
	parameter int CACHE_INDEX_BITS = 4
) (
	input logic i_clock,
	input logic i_reset,

	// CPU side.
	input logic i_request,
	input dcache_pkg::cpu_req_t i_req,
	output logic o_ready,
	output mem_bus_pkg::word_t o_rdata,

	// Memory bus.
	output logic o_bus_request,
	output mem_bus_pkg::bus_req_t o_bus_req,
	input logic i_bus_ready,
	input mem_bus_pkg::word_t i_bus_rdata
);

	import dcache_pkg::*;
	import mem_bus_pkg::*;

	typedef enum logic [3:0] {
		IDLE,
		FLUSH_SETUP,
		FLUSH_CHECK,
		FLUSH_WRITE,
		PASS_THROUGH,
		WRITE_SETUP,
		WRITE_WAIT,
		READ_SETUP,
		READ_WB_WAIT,
		READ_BUS_WAIT
	} state_t;

	state_t state;
	state_t next_state;

	// One extra bit marks the end of the flush walk.
	logic [CACHE_INDEX_BITS:0] flush_address;
	logic [CACHE_INDEX_BITS:0] next_flush_address;

	// Store port.
	logic cache_initialized;
	logic cache_write;
	logic [CACHE_INDEX_BITS-1:0] cache_address;
	cache_entry_t cache_wdata;
	cache_entry_t entry;

	logic [CACHE_INDEX_BITS-1:0] req_index;
	logic [CACHE_INDEX_BITS-1:0] flush_index;
	logic [29:0] req_tag;
	logic hit;
	logic conflict;

	// Lines and bus commands the FSM picks from.
	cache_entry_t entry_store;
	cache_entry_t entry_fill;
	cache_entry_t entry_cleaned;
	bus_req_t bus_victim;
	bus_req_t bus_fill;
	bus_req_t bus_pass;

	// Read data follows the address by one cycle.
	ram_clear #(
		.DEPTH_BITS(CACHE_INDEX_BITS),
		.T_WORD(cache_entry_t),
		.CLEAR_VALUE(ENTRY_CLEAR)
	) u_ram (
		.i_clock(i_clock),
		.i_reset(i_reset),
		.i_write(cache_write),
		.i_address(cache_address),
		.i_wdata(cache_wdata),
		.o_rdata(entry),
		.o_initialized(cache_initialized)
	);

	assign req_index = i_req.address[CACHE_INDEX_BITS+1:2];
	assign req_tag = i_req.address[31:2];
	assign flush_index = flush_address[CACHE_INDEX_BITS-1:0];

	assign hit = entry.valid && (entry.tag == req_tag);
	// Dirty line of another address must go out before this one lands.
	assign conflict = entry.dirty && (entry.tag != req_tag);

	assign entry_store = '{data: i_req.wdata, tag: req_tag, dirty: 1'b1, valid: 1'b1};
	assign entry_fill = '{data: i_bus_rdata, tag: req_tag, dirty: 1'b0, valid: 1'b1};
	assign entry_cleaned = '{data: entry.data, tag: entry.tag, dirty: 1'b0, valid: entry.valid};

	assign bus_victim = '{rw: 1'b1, address: {entry.tag, 2'b00}, wdata: entry.data};
	assign bus_fill = '{rw: 1'b0, address: i_req.address, wdata: '0};
	assign bus_pass = '{rw: i_req.rw, address: i_req.address, wdata: i_req.wdata};

	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			state <= IDLE;
			flush_address <= '0;
		end else begin
			state <= next_state;
			flush_address <= next_flush_address;
		end
	end

	always_comb begin
		next_state = state;
		next_flush_address = flush_address;

		o_ready = 1'b0;
		o_rdata = '0;
		o_bus_request = 1'b0;
		o_bus_req = '0;

		cache_write = 1'b0;
		cache_wdata = ENTRY_CLEAR;
		cache_address = req_index;

		case (state)
			// Store is read at the request index here, ready for the next state.
			IDLE: begin
				if (i_request) begin
					if (i_req.flush) begin
						if (cache_initialized) begin
							next_flush_address = '0;
							next_state = FLUSH_SETUP;
						end else begin
							o_ready = 1'b1;
						end
					end else if (cache_initialized && i_req.cacheable) begin
						next_state = i_req.rw ? WRITE_SETUP : READ_SETUP;
					end else begin
						o_bus_request = 1'b1;
						o_bus_req = bus_pass;
						next_state = PASS_THROUGH;
					end
				end
			end

			// ==============================
			// Flush
			// ==============================

			FLUSH_SETUP: begin
				cache_address = flush_index;
				if (flush_address[CACHE_INDEX_BITS]) begin
					o_ready = 1'b1;
					next_state = IDLE;
				end else begin
					next_state = FLUSH_CHECK;
				end
			end

			FLUSH_CHECK: begin
				cache_address = flush_index;
				if (entry.dirty) begin
					o_bus_request = 1'b1;
					o_bus_req = bus_victim;
					next_state = FLUSH_WRITE;
				end else begin
					next_flush_address = flush_address + 1'b1;
					next_state = FLUSH_SETUP;
				end
			end

			// Line stays put, only the dirty bit goes.
			FLUSH_WRITE: begin
				cache_address = flush_index;
				o_bus_request = 1'b1;
				o_bus_req = bus_victim;
				if (i_bus_ready) begin
					cache_write = 1'b1;
					cache_wdata = entry_cleaned;
					next_flush_address = flush_address + 1'b1;
					next_state = FLUSH_SETUP;
				end
			end

			// ==============================
			// Uncached
			// ==============================

			PASS_THROUGH: begin
				o_bus_request = 1'b1;
				o_bus_req = bus_pass;
				o_rdata = i_bus_rdata;
				if (i_bus_ready) begin
					o_ready = 1'b1;
					next_state = IDLE;
				end
			end

			// ==============================
			// Write
			// ==============================

			WRITE_SETUP: begin
				if (conflict) begin
					o_bus_request = 1'b1;
					o_bus_req = bus_victim;
					next_state = WRITE_WAIT;
				end else begin
					cache_write = 1'b1;
					cache_wdata = entry_store;
					o_ready = 1'b1;
					next_state = IDLE;
				end
			end

			// Victim goes out first, then the new word takes the line.
			WRITE_WAIT: begin
				o_bus_request = 1'b1;
				o_bus_req = bus_victim;
				if (i_bus_ready) begin
					cache_write = 1'b1;
					cache_wdata = entry_store;
					o_ready = 1'b1;
					next_state = IDLE;
				end
			end

			// ==============================
			// Read
			// ==============================

			READ_SETUP: begin
				o_rdata = entry.data;
				if (hit) begin
					o_ready = 1'b1;
					next_state = IDLE;
				end else if (entry.dirty) begin
					o_bus_request = 1'b1;
					o_bus_req = bus_victim;
					next_state = READ_WB_WAIT;
				end else begin
					o_bus_request = 1'b1;
					o_bus_req = bus_fill;
					next_state = READ_BUS_WAIT;
				end
			end

			// Refill starts as a fresh bus transaction right after this ready.
			READ_WB_WAIT: begin
				o_bus_request = 1'b1;
				o_bus_req = bus_victim;
				if (i_bus_ready) begin
					next_state = READ_BUS_WAIT;
				end
			end

			READ_BUS_WAIT: begin
				o_bus_request = 1'b1;
				o_bus_req = bus_fill;
				o_rdata = i_bus_rdata;
				if (i_bus_ready) begin
					cache_write = 1'b1;
					cache_wdata = entry_fill;
					o_ready = 1'b1;
					next_state = IDLE;
				end
			end

			default: begin
				next_state = IDLE;
			end
		endcase
	end

endmodule

/* src/dcache_pkg.sv */
package dcache_pkg;

	// ==============================
	// CPU side
	// ==============================

	// One CPU access. For a flush only the flush bit counts.
	typedef struct packed {
		logic rw;
		logic flush;
		logic cacheable;
		logic [31:0] address;
		logic [31:0] wdata;
	} cpu_req_t;

	// ==============================
	// Cache store
	// ==============================

	// One line of the store, one word wide.
	// The tag is the full word address, so a line rebuilds its own address.
	// Valid sits in bit 0 and dirty in bit 1.
	typedef struct packed {
		logic [31:0] data;
		logic [29:0] tag;
		logic dirty;
		logic valid;
	} cache_entry_t;

	// Invalid and clean, written to every line after reset.
	localparam cache_entry_t ENTRY_CLEAR = '0;

endpackage

/* src/dcache_system.sv */
`timescale 1ns/1ps

module dcache_system #(
	parameter int CACHE_INDEX_BITS = 4,
	parameter int MEM_ADDR_BITS = 8,
	parameter int MEM_LATENCY = 3
) (
	input logic i_clock,
	input logic i_reset,
	input logic i_request,
	input dcache_pkg::cpu_req_t i_req,
	output logic o_ready,
	output mem_bus_pkg::word_t o_rdata
);

	import mem_bus_pkg::*;

	// ==============================
	// Cache to memory bus
	// ==============================

	logic bus_request;
	bus_req_t bus_req;
	logic bus_ready;
	word_t bus_rdata;

	dcache #(
		.CACHE_INDEX_BITS(CACHE_INDEX_BITS)
	) u_dcache (
		.i_clock(i_clock),
		.i_reset(i_reset),
		.i_request(i_request),
		.i_req(i_req),
		.o_ready(o_ready),
		.o_rdata(o_rdata),
		.o_bus_request(bus_request),
		.o_bus_req(bus_req),
		.i_bus_ready(bus_ready),
		.i_bus_rdata(bus_rdata)
	);

	// Only master on the bus is the cache.
	bus_memory #(
		.MEM_ADDR_BITS(MEM_ADDR_BITS),
		.MEM_LATENCY(MEM_LATENCY)
	) u_bus_memory (
		.i_clock(i_clock),
		.i_reset(i_reset),
		.i_request(bus_request),
		.i_req(bus_req),
		.o_ready(bus_ready),
		.o_rdata(bus_rdata)
	);

endmodule

/* src/mem_bus_pkg.sv */
package mem_bus_pkg;

	// ==============================
	// Memory bus
	// ==============================

	// Data word on the bus and in memory.
	typedef logic [31:0] word_t;

	// Bus command, held stable until ready.
	// The address is a byte address. Memory uses the word part.
	typedef struct packed {
		logic rw;
		logic [31:0] address;
		word_t wdata;
	} bus_req_t;

endpackage

/* src/ram_clear.sv */
`timescale 1ns/1ps

module ram_clear #(
	parameter int DEPTH_BITS = 4,
	parameter type T_WORD = logic [31:0],
	parameter T_WORD CLEAR_VALUE = '0
) (
	input logic i_clock,
	input logic i_reset,
	input logic i_write,
	input logic [DEPTH_BITS-1:0] i_address,
	input T_WORD i_wdata,
	output T_WORD o_rdata,
	output logic o_initialized
);

	localparam int DEPTH = 1 << DEPTH_BITS;

	T_WORD memory [DEPTH];

	logic clearing;
	logic [DEPTH_BITS-1:0] clear_address;

	logic ram_write;
	logic [DEPTH_BITS-1:0] ram_address;
	T_WORD ram_wdata;

	// Clear sequencer, one word per cycle once reset is released.
	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			clearing <= 1'b1;
			clear_address <= '0;
			o_initialized <= 1'b0;
		end else if (clearing) begin
			clear_address <= clear_address + 1'b1;
			if (&clear_address) begin
				clearing <= 1'b0;
				o_initialized <= 1'b1;
			end
		end
	end

	// The clear pass owns the port until it is done.
	// Port writes are dropped before that.
	assign ram_address = clearing ? clear_address : i_address;
	assign ram_wdata = clearing ? CLEAR_VALUE : i_wdata;
	assign ram_write = clearing || (o_initialized && i_write);

	// Read data shows the old word when reading the address being written.
	always_ff @(posedge i_clock) begin
		if (ram_write) begin
			memory[ram_address] <= ram_wdata;
		end
		o_rdata <= memory[ram_address];
	end

endmodule

/* test/dcache_system_properties.sv */
`timescale 1ns/1ps

module dcache_properties (
	input logic i_clock,
	input logic i_reset,
	input logic o_ready,
	input logic o_bus_request,
	input mem_bus_pkg::bus_req_t o_bus_req,
	input logic i_bus_ready
);

	// High from the second reset edge on, once the FSM state is known.
	logic reset_held;

	always_ff @(posedge i_clock) begin
		reset_held <= i_reset;
	end

	// ==============================
	// Checks
	// ==============================

	// Both outputs stay low while reset is held.
	assert property (@(posedge i_clock) (i_reset && reset_held) |-> (!o_ready && !o_bus_request))
		else $error("o_ready or o_bus_request high during reset");

	// The bus command holds until memory answers.
	assert property (@(posedge i_clock) disable iff (i_reset)
		(o_bus_request && !i_bus_ready) |=> (o_bus_request && $stable(o_bus_req)))
		else $error("bus command changed before i_bus_ready");

	// One pulse per transaction.
	assert property (@(posedge i_clock) disable iff (i_reset) o_ready |=> !o_ready)
		else $error("o_ready high in two consecutive cycles");

endmodule

bind dcache dcache_properties u_properties (
	.i_clock(i_clock),
	.i_reset(i_reset),
	.o_ready(o_ready),
	.o_bus_request(o_bus_request),
	.o_bus_req(o_bus_req),
	.i_bus_ready(i_bus_ready)
);

/* test/dcache_system_tb.sv */
`timescale 1ns/1ps

module dcache_system_tb;

	import dcache_pkg::*;
	import mem_bus_pkg::*;

	localparam int CACHE_INDEX_BITS = 4;
	localparam int MEM_ADDR_BITS = 8;
	localparam int MEM_LATENCY = 3;

	localparam int MEM_WORDS = 1 << MEM_ADDR_BITS;
	// Byte address where the uncached half of memory starts.
	localparam logic [31:0] UNCACHED_BASE = 32'(MEM_WORDS * 2);
	localparam int READY_TIMEOUT = 200;
	localparam int INIT_TIMEOUT = 4 * MEM_WORDS;
	// A hit shows on the second falling edge after the request is driven.
	localparam int HIT_CYCLES = 2;

	logic clock;
	logic reset;
	logic request;
	cpu_req_t req;
	logic ready;
	word_t rdata;
	logic all_initialized;

	// Reference memory keyed by word address.
	word_t ref_mem [int unsigned];

	logic expect_read;
	word_t expect_data;
	int error_count;
	int check_count;
	int tests_passed;
	int tests_failed;
	int last_cycles;
	logic timed_out;

	dcache_system #(
		.CACHE_INDEX_BITS(CACHE_INDEX_BITS),
		.MEM_ADDR_BITS(MEM_ADDR_BITS),
		.MEM_LATENCY(MEM_LATENCY)
	) u_dcache_system (
		.i_clock(clock),
		.i_reset(reset),
		.i_request(request),
		.i_req(req),
		.o_ready(ready),
		.o_rdata(rdata)
	);

	assign all_initialized = u_dcache_system.u_dcache.cache_initialized
		&& u_dcache_system.u_bus_memory.initialized;

	always #20 clock = ~clock;

	// Unwritten words read as zero. Addresses wrap with the memory size.
	function automatic word_t expected_read(input logic [31:0] address);
		int unsigned key;
		key = (address >> 2) % MEM_WORDS;
		if (ref_mem.exists(key)) begin
			return ref_mem[key];
		end
		return '0;
	endfunction

	// ==============================
	// Read data check
	// ==============================

	always @(negedge clock) begin
		if (ready && expect_read) begin
			check_count++;
			if (rdata !== expect_data) begin
				error_count++;
				$display("FAIL t=%0t o_rdata: expected %h, got %h", $time, expect_data, rdata);
			end
		end
	end

	task automatic wait_initialized();
		int cycles;
		cycles = 0;
		while (!all_initialized && cycles < INIT_TIMEOUT) begin
			@(negedge clock);
			cycles++;
		end
		if (!all_initialized) begin
			timed_out = 1'b1;
			$display("Timeout: cache and memory did not finish clearing");
		end
	endtask

	// One CPU transaction, from driving the request to dropping it.
	task automatic access(input logic is_write, input logic is_flush, input logic is_cacheable,
		input logic [31:0] address, input word_t wdata);
		int cycles;
		if (timed_out) begin
			return;
		end
		@(posedge clock);
		request <= 1'b1;
		req <= '{rw: is_write, flush: is_flush, cacheable: is_cacheable,
			address: address, wdata: wdata};
		expect_read = !is_write && !is_flush;
		expect_data = expected_read(address);
		if (is_write && !is_flush) begin
			ref_mem[(address >> 2) % MEM_WORDS] = wdata;
		end
		cycles = 0;
		do begin
			@(negedge clock);
			cycles++;
		end while (!ready && cycles < READY_TIMEOUT);
		if (!ready) begin
			timed_out = 1'b1;
			$display("Timeout at %0t: no o_ready for address %h", $time, address);
		end
		last_cycles = cycles;
		@(posedge clock);
		request <= 1'b0;
		expect_read = 1'b0;
	endtask

	task automatic write_word(input logic cacheable, input logic [31:0] address,
		input word_t data);
		access(1'b1, 1'b0, cacheable, address, data);
	endtask

	task automatic read_word(input logic cacheable, input logic [31:0] address);
		access(1'b0, 1'b0, cacheable, address, '0);
	endtask

	task automatic flush_cache();
		access(1'b0, 1'b1, 1'b0, '0, '0);
	endtask

	task automatic report_test(input string name, input int errors_before);
		if (error_count == errors_before && !timed_out) begin
			tests_passed++;
			$display("Test %s: passed", name);
		end else begin
			tests_failed++;
			$display("Test %s: failed with %0d errors", name, error_count - errors_before);
		end
	endtask

	// ==============================
	// Stimulus
	// ==============================

	initial begin
		int errors_before;
		logic [31:0] address;

		clock = 1'b0;
		reset = 1'b1;
		request = 1'b0;
		req = '0;
		expect_read = 1'b0;
		expect_data = '0;
		error_count = 0;
		check_count = 0;
		tests_passed = 0;
		tests_failed = 0;
		last_cycles = 0;
		timed_out = 1'b0;
		void'($urandom(32'h907742a0));

		repeat (16) @(posedge clock);
		reset <= 1'b0;
		wait_initialized();

		errors_before = error_count;
		write_word(1'b0, UNCACHED_BASE + 32'h100, 32'hcafe_0001);
		read_word(1'b0, UNCACHED_BASE + 32'h100);
		report_test("uncached write and read", errors_before);

		errors_before = error_count;
		write_word(1'b1, 32'h010, 32'h1234_5678);
		read_word(1'b1, 32'h010);
		if (!timed_out && last_cycles != HIT_CYCLES) begin
			error_count++;
			$display("FAIL t=%0t o_ready latency: expected %0d, got %0d", $time,
				HIT_CYCLES, last_cycles);
		end
		report_test("cached write and read hit", errors_before);

		// Same index, different tags.
		errors_before = error_count;
		write_word(1'b1, 32'h040, 32'haaaa_0040);
		write_word(1'b1, 32'h080, 32'hbbbb_0080);
		read_word(1'b1, 32'h040);
		read_word(1'b1, 32'h080);
		report_test("index conflict", errors_before);

		errors_before = error_count;
		for (int i = 0; i < 4; i++) begin
			write_word(1'b1, 32'h100 + 32'(i * 4), 32'hf100_0000 + 32'(i));
		end
		flush_cache();
		for (int i = 0; i < 4; i++) begin
			read_word(1'b0, 32'h100 + 32'(i * 4));
		end
		report_test("flush to memory", errors_before);

		errors_before = error_count;
		for (int i = 0; i < 200; i++) begin
			address = ($urandom % 64) << 2;
			if ($urandom % 2 == 1) begin
				write_word(1'b1, address, $urandom);
			end else begin
				read_word(1'b1, address);
			end
		end
		report_test("random cached traffic", errors_before);

		$display("Tests passed: %0d, failed: %0d, reads checked: %0d, errors: %0d",
			tests_passed, tests_failed, check_count, error_count);
		if (error_count == 0 && tests_failed == 0 && !timed_out) begin
			$display("Everything OK");
		end else begin
			$display("Something failed");
		end
		$finish;
	end

endmodule
